//--- rtl/sld_pkg.sv
// Shared constants and types of the vector slide unit
// Every slide block takes what it needs from here

`default_nettype none

package sld_pkg;

  //////////////////////////////////////////////////
  // Datapath constants
  //////////////////////////////////////////////////

  // Bytes in one lane word, a single 64-bit element
  localparam int unsigned ElenBytes  = 8;
  // Upper bound of a vector length in bytes
  localparam int unsigned MaxVlBytes = 256;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Element width, encoded directly as its byte shift amount
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Slide direction
  typedef enum logic {
    SLD_UP   = 1'b0,
    SLD_DOWN = 1'b1
  } sld_op_e;

  typedef logic [2:0] vid_t;
  typedef logic [4:0] vreg_t;
  // Wide enough to hold MaxVlBytes itself
  typedef logic [$clog2(MaxVlBytes+1)-1:0] vlen_t;
  // Row address into the register file
  typedef logic [7:0] vaddr_t;

  // Queued instruction, lengths already in bytes
  typedef struct packed {
    vid_t    id;
    sld_op_e op;
    vew_e    vew;
    vlen_t   vl_bytes;
    vlen_t   offset_bytes;
    vreg_t   vd;
  } sld_insn_t;

endpackage

`default_nettype wire

//--- rtl/sld_spill_reg.sv
// Two-entry valid/ready register, cuts every combinational path
// Serves as the operand cut and as the result queue of the slide unit

`timescale 1ns/10ps
`default_nettype none

module sld_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new items, slot B keeps the older one while the output stalls
  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  // A moves on whenever B is free, either out or into B
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B is always the older entry
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  // Only both slots full blocks the input
  assign ready_o = !a_full_q || !b_full_q;

  // A stalled item stays put until it is taken
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

//--- rtl/sld_insn_queue.sv
// Circular queue of slide instructions between acceptance and commit
// The issue head is handed to the issue stage, slots free on commit

`timescale 1ns/10ps
`default_nettype none

module sld_insn_queue #(
  parameter int unsigned InsnQueueDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer requests
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  sld_pkg::vid_t        req_id_i,
  input  sld_pkg::sld_op_e     req_op_i,
  input  sld_pkg::vew_e        req_vew_i,
  input  sld_pkg::vlen_t       req_vl_i,
  input  sld_pkg::vlen_t       req_stride_i,
  input  sld_pkg::vreg_t       req_vd_i,
  // Issue head
  output sld_pkg::sld_insn_t   issue_insn_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  // Last row of the commit head granted
  input  logic                 commit_i
);

  import sld_pkg::*;

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  sld_insn_t          mem_q [InsnQueueDepth];
  logic [PtrW-1:0]    accept_pnt_q;
  logic [PtrW-1:0]    issue_pnt_q;
  // Instructions waiting for issue, and those not yet committed
  logic [CntW-1:0]    issue_cnt_q;
  logic [CntW-1:0]    commit_cnt_q;
  logic               accept;

  assign req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;

  // Store with element counts and stride turned into bytes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q].id           <= req_id_i;
      mem_q[accept_pnt_q].op           <= req_op_i;
      mem_q[accept_pnt_q].vew          <= req_vew_i;
      mem_q[accept_pnt_q].vl_bytes     <= vlen_t'(req_vl_i << req_vew_i);
      mem_q[accept_pnt_q].offset_bytes <= vlen_t'(req_stride_i << req_vew_i);
      mem_q[accept_pnt_q].vd           <= req_vd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == PtrW'(InsnQueueDepth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= (issue_pnt_q == PtrW'(InsnQueueDepth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_i);
    end
  end

  // Head is valid from the cycle after acceptance
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = mem_q[issue_pnt_q];

  // Never overfill, and issue never runs ahead of the uncommitted set
  a_no_overfill : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (commit_cnt_q < CntW'(InsnQueueDepth)) && (issue_cnt_q <= commit_cnt_q));

  // A commit only follows the issue stage finishing that instruction
  a_commit_after_issue : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_cnt_q > issue_cnt_q);

endmodule

`default_nettype wire

//--- rtl/sld_issue.sv
// Slide issue stage, walks input and output byte pointers over the rows
// Builds one destination row at a time with its byte enables

`timescale 1ns/10ps
`default_nettype none

module sld_issue #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned RegRows = 8
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Issue head of the instruction queue
  input  sld_pkg::sld_insn_t                           insn_i,
  input  logic                                         insn_valid_i,
  output logic                                         issue_done_o,
  // Source rows
  input  logic [NrLanes*sld_pkg::ElenBytes*8-1:0]      row_i,
  input  logic                                         row_valid_i,
  output logic                                         row_ready_o,
  // Destination rows towards the result queue
  output logic                                         res_valid_o,
  input  logic                                         res_ready_i,
  output sld_pkg::vaddr_t                              res_addr_o,
  output logic [NrLanes*sld_pkg::ElenBytes*8-1:0]      res_wdata_o,
  output logic [NrLanes*sld_pkg::ElenBytes-1:0]        res_be_o,
  output sld_pkg::vid_t                                res_id_o,
  output logic                                         res_last_o
);

  import sld_pkg::*;

  localparam int unsigned RowBytes = NrLanes * ElenBytes;
  localparam int unsigned RowW     = RowBytes * 8;
  localparam int unsigned IdxW     = $clog2(RowBytes);
  // One extra bit so a pointer can reach RowBytes before wrapping
  localparam int unsigned PntW     = IdxW + 1;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e                state_q;
  logic [PntW-1:0]       in_pnt_q;
  logic [PntW-1:0]       out_pnt_q;
  vaddr_t                row_pnt_q;
  // Bytes still to be written for this instruction
  vlen_t                 cnt_q;
  // Partially built destination row
  logic [RowW-1:0]       wdata_q;
  logic [RowBytes-1:0]   be_q;

  logic                  start;
  logic                  step_en;
  logic [PntW-1:0]       in_gap;
  logic [PntW-1:0]       out_gap;
  logic [PntW-1:0]       byte_count;
  logic [PntW-1:0]       step;
  logic [PntW-1:0]       in_end;
  logic [PntW-1:0]       out_end;
  logic [PntW-1:0]       wr_end;
  logic                  last;
  logic                  in_wrap;
  logic                  emit;
  logic [IdxW-1:0]       rot;
  logic [2*RowW-1:0]     row_dbl;
  logic [RowW-1:0]       shifted;
  logic [RowBytes-1:0]   en;
  logic [RowW-1:0]       wdata_next;

  assign start   = (state_q == ST_IDLE) && insn_valid_i;
  // One chunk per cycle, stalled as a whole on operand or result back-pressure
  assign step_en = (state_q == ST_RUN) && row_valid_i && res_ready_i;

  //////////////////////////////////////////////////
  // Pointer walk
  //////////////////////////////////////////////////

  assign in_gap     = PntW'(RowBytes) - in_pnt_q;
  assign out_gap    = PntW'(RowBytes) - out_pnt_q;
  assign byte_count = (in_gap < out_gap) ? in_gap : out_gap;
  // Clip the chunk at the end of the vector
  assign last       = (cnt_q <= vlen_t'(byte_count));
  assign step       = last ? PntW'(cnt_q) : byte_count;
  assign in_end     = in_pnt_q + byte_count;
  assign out_end    = out_pnt_q + byte_count;
  assign wr_end     = out_pnt_q + step;
  assign in_wrap    = (in_end == PntW'(RowBytes));
  assign emit       = (out_end == PntW'(RowBytes)) || last;

  //////////////////////////////////////////////////
  // Byte shifter and enables
  //////////////////////////////////////////////////

  // Rotate left by out minus in, so input byte in_pnt lands on out_pnt
  assign rot     = IdxW'(out_pnt_q - in_pnt_q);
  assign row_dbl = {row_i, row_i} >> (8 * (RowBytes - rot));
  assign shifted = row_dbl[RowW-1:0];

  always_comb begin
    for (int unsigned b = 0; b < RowBytes; b++) begin
      en[b] = (PntW'(b) >= out_pnt_q) && (PntW'(b) < wr_end);
      wdata_next[8*b +: 8] = en[b] ? shifted[8*b +: 8] : wdata_q[8*b +: 8];
    end
  end

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      row_pnt_q <= '0;
      cnt_q     <= '0;
      be_q      <= '0;
    end else if (start) begin
      state_q <= ST_RUN;
      be_q    <= '0;
      if (insn_i.op == SLD_UP) begin
        // Read from the source start, write from the offset on
        in_pnt_q  <= '0;
        out_pnt_q <= PntW'(insn_i.offset_bytes[IdxW-1:0]);
        row_pnt_q <= vaddr_t'(insn_i.offset_bytes >> IdxW);
        cnt_q     <= insn_i.vl_bytes - insn_i.offset_bytes;
      end else begin
        // Skip the offset in the source, write from byte 0
        in_pnt_q  <= PntW'(insn_i.offset_bytes[IdxW-1:0]);
        out_pnt_q <= '0;
        row_pnt_q <= '0;
        cnt_q     <= insn_i.vl_bytes;
      end
    end else if (step_en) begin
      cnt_q    <= cnt_q - vlen_t'(step);
      in_pnt_q <= (in_wrap || last) ? '0 : in_end;
      if (emit) begin
        out_pnt_q <= '0;
        row_pnt_q <= row_pnt_q + 1'b1;
        be_q      <= '0;
      end else begin
        out_pnt_q <= out_end;
        be_q      <= be_q | en;
      end
      if (last) state_q <= ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start || (step_en && emit)) begin
      wdata_q <= '0;
    end else if (step_en) begin
      wdata_q <= wdata_next;
    end
  end

  // Input row is done once fully read, or the instruction ends
  assign row_ready_o  = step_en && (in_wrap || last);
  assign issue_done_o = step_en && last;

  assign res_valid_o = step_en && emit;
  assign res_addr_o  = vaddr_t'(insn_i.vd * RegRows) + row_pnt_q;
  assign res_wdata_o = wdata_next;
  assign res_be_o    = be_q | en;
  assign res_id_o    = insn_i.id;
  assign res_last_o  = last;

  // Both pointers stay inside one row for the whole walk
  a_pnt_in_row : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ST_RUN |-> (in_pnt_q < PntW'(RowBytes)) && (out_pnt_q < PntW'(RowBytes)));

endmodule

`default_nettype wire

//--- rtl/sld_unit.sv
// Top level of the slide unit for vslideup and vslidedown
// Queue, operand cut, issue stage and result queue, plus the done pulse

`timescale 1ns/10ps
`default_nettype none

module sld_unit #(
  parameter  int unsigned NrLanes        = 4,
  parameter  int unsigned RegRows        = 8,
  parameter  int unsigned InsnQueueDepth = 2,
  localparam int unsigned RowBytes       = NrLanes * sld_pkg::ElenBytes
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Sequencer side
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  sld_pkg::vid_t           req_id_i,
  input  sld_pkg::sld_op_e        req_op_i,
  input  sld_pkg::vew_e           req_vew_i,
  input  sld_pkg::vlen_t          req_vl_i,
  input  sld_pkg::vlen_t          req_stride_i,
  input  sld_pkg::vreg_t          req_vd_i,
  // Operand rows
  input  logic [RowBytes*8-1:0]   operand_i,
  input  logic                    operand_valid_i,
  output logic                    operand_ready_o,
  // Register file writes
  output logic                    result_req_o,
  output sld_pkg::vaddr_t         result_addr_o,
  output logic [RowBytes*8-1:0]   result_wdata_o,
  output logic [RowBytes-1:0]     result_be_o,
  input  logic                    result_gnt_i,
  // Completion
  output logic                    done_o,
  output sld_pkg::vid_t           done_id_o
);

  import sld_pkg::*;

  typedef logic [RowBytes*8-1:0] row_t;

  // Destination row as held in the result queue
  typedef struct packed {
    vaddr_t                addr;
    row_t                  wdata;
    logic [RowBytes-1:0]   be;
    vid_t                  id;
    logic                  last;
  } payload_t;

  sld_insn_t  issue_insn;
  logic       issue_valid;
  logic       issue_done;
  row_t       row;
  logic       row_valid;
  logic       row_ready;
  logic       res_valid;
  logic       res_ready;
  payload_t   res_payload;
  payload_t   out_payload;
  logic       commit_q;
  vid_t       done_id_q;

  sld_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_id_i      (req_id_i),
    .req_op_i      (req_op_i),
    .req_vew_i     (req_vew_i),
    .req_vl_i      (req_vl_i),
    .req_stride_i  (req_stride_i),
    .req_vd_i      (req_vd_i),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_i      (commit_q)
  );

  sld_spill_reg #(
    .T (row_t)
  ) u_operand_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (operand_valid_i),
    .ready_o (operand_ready_o),
    .data_i  (operand_i),
    .valid_o (row_valid),
    .ready_i (row_ready),
    .data_o  (row)
  );

  sld_issue #(
    .NrLanes (NrLanes),
    .RegRows (RegRows)
  ) u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (issue_insn),
    .insn_valid_i (issue_valid),
    .issue_done_o (issue_done),
    .row_i        (row),
    .row_valid_i  (row_valid),
    .row_ready_o  (row_ready),
    .res_valid_o  (res_valid),
    .res_ready_i  (res_ready),
    .res_addr_o   (res_payload.addr),
    .res_wdata_o  (res_payload.wdata),
    .res_be_o     (res_payload.be),
    .res_id_o     (res_payload.id),
    .res_last_o   (res_payload.last)
  );

  sld_spill_reg #(
    .T (payload_t)
  ) u_result_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (res_valid),
    .ready_o (res_ready),
    .data_i  (res_payload),
    .valid_o (result_req_o),
    .ready_i (result_gnt_i),
    .data_o  (out_payload)
  );

  assign result_addr_o  = out_payload.addr;
  assign result_wdata_o = out_payload.wdata;
  assign result_be_o    = out_payload.be;

  //////////////////////////////////////////////////
  // Commit and done pulse
  //////////////////////////////////////////////////

  // Granted last row retires the commit head one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q <= 1'b0;
    end else begin
      commit_q <= result_req_o && result_gnt_i && out_payload.last;
    end
  end

  always_ff @(posedge clk_i) begin
    done_id_q <= out_payload.id;
  end

  assign done_o    = commit_q;
  assign done_id_o = done_id_q;

endmodule

`default_nettype wire

//--- bench/tb_sld_model.svh
// Reference model of the slide rule, included in the testbench module body
// Queues the expected rows, the source rows to send and the done id per slide

`ifndef TB_SLD_MODEL_SVH
`define TB_SLD_MODEL_SVH

// D is the destination byte index, counted from the start of the register group
task automatic model_slide(input logic down, input int vl_b, input int off_b,
                           input int vd, input int id);
  int lo;
  int d;
  int r;
  int b;
  logic [RowW-1:0]     data;
  logic [RowBytes-1:0] be;
  // Slide up leaves the bytes below the offset alone
  lo = down ? 0 : off_b;
  for (r = lo / RowBytes; r <= (vl_b - 1) / RowBytes; r++) begin
    data = '0;
    be   = '0;
    for (b = 0; b < RowBytes; b++) begin
      d = r * RowBytes + b;
      if (d >= lo && d < vl_b) begin
        be[b]          = 1'b1;
        data[8*b +: 8] = down ? src_mem[d + off_b] : src_mem[d - off_b];
      end
    end
    exp_addr_q.push_back(8'(vd * RegRows + r));
    exp_data_q.push_back(data);
    exp_be_q.push_back(be);
  end
  // Source rows in the order the slide reads them
  if (down) begin
    for (r = off_b / RowBytes; r <= (off_b + vl_b - 1) / RowBytes; r++) rows_q.push_back(r);
  end else begin
    for (r = 0; r <= (vl_b - off_b - 1) / RowBytes; r++) rows_q.push_back(r);
  end
  exp_done_q.push_back(id);
endtask

`endif

//--- bench/tb_sld_unit.sv
// Directed testbench of the slide unit
// Each test queues slides, feeds source rows and checks rows and done ids

`timescale 1ns/10ps
`default_nettype none

module tb_sld_unit;

  import sld_pkg::*;

  localparam int NrLanes        = 4;
  localparam int RegRows        = 8;
  localparam int InsnQueueDepth = 2;
  localparam int RowBytes       = NrLanes * ElenBytes;
  localparam int RowW           = RowBytes * 8;
  // Rough cycle budget of each test
  localparam int LenAlignedUp   = 20;
  localparam int LenOddDown     = 20;
  localparam int LenStalledUp   = 60;
  localparam int LenGapsDown    = 60;
  localparam int LenBurst       = 80;
  localparam int TimeoutCycles  =
    4 * (LenAlignedUp + LenOddDown + LenStalledUp + LenGapsDown + LenBurst);

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i;
  logic                req_ready_o;
  vid_t                req_id_i;
  sld_op_e             req_op_i;
  vew_e                req_vew_i;
  vlen_t               req_vl_i;
  vlen_t               req_stride_i;
  vreg_t               req_vd_i;
  logic [RowW-1:0]     operand_i;
  logic                operand_valid_i;
  logic                operand_ready_o;
  logic                result_req_o;
  vaddr_t              result_addr_o;
  logic [RowW-1:0]     result_wdata_o;
  logic [RowBytes-1:0] result_be_o;
  logic                result_gnt_i;
  logic                done_o;
  vid_t                done_id_o;

  // Source bytes of the register group, refilled per test
  logic [7:0]          src_mem [0:511];
  logic [7:0]          exp_addr_q [$];
  logic [RowW-1:0]     exp_data_q [$];
  logic [RowBytes-1:0] exp_be_q [$];
  int                  exp_done_q [$];
  int                  rows_q [$];
  // Slides of the running test
  sld_op_e             ins_op [3];
  vew_e                ins_vew [3];
  int                  ins_vl [3];
  int                  ins_stride [3];
  int                  ins_vd [3];
  int                  ins_id [3];
  int                  ins_cnt;
  logic                saw_full;
  logic [31:0]         lfsr_q;
  int                  err_cnt = 0;
  int                  test_cnt = 0;
  int                  failed_cnt = 0;
  int                  cycle_cnt = 0;

  `include "tb_sld_model.svh"

  sld_unit #(
    .NrLanes        (NrLanes),
    .RegRows        (RegRows),
    .InsnQueueDepth (InsnQueueDepth)
  ) u_sld_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_id_i        (req_id_i),
    .req_op_i        (req_op_i),
    .req_vew_i       (req_vew_i),
    .req_vl_i        (req_vl_i),
    .req_stride_i    (req_stride_i),
    .req_vd_i        (req_vd_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_addr_o   (result_addr_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o),
    .done_id_o       (done_id_o)
  );

  always #20 clk_i = ~clk_i;

  // Ends a run whose DUT stopped answering
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [RowW-1:0] row_data(input int r);
    logic [RowW-1:0] v;
    int              b;
    for (b = 0; b < RowBytes; b++) v[8*b +: 8] = src_mem[r * RowBytes + b];
    return v;
  endfunction

  function automatic logic [RowW-1:0] be_mask(input logic [RowBytes-1:0] be);
    logic [RowW-1:0] m;
    int              b;
    for (b = 0; b < RowBytes; b++) m[8*b +: 8] = {8{be[b]}};
    return m;
  endfunction

  task automatic fill_source();
    int a;
    for (a = 0; a < 512; a++) src_mem[a] = 8'(rand_bits(8));
  endtask

  task automatic clear_slides();
    ins_cnt  = 0;
    saw_full = 1'b0;
  endtask

  // Lengths and offsets in bytes are the element counts shifted by the width
  task automatic add_slide(input int id, input sld_op_e op, input vew_e vew,
                           input int vl, input int stride, input int vd);
    ins_id[ins_cnt]     = id;
    ins_op[ins_cnt]     = op;
    ins_vew[ins_cnt]    = vew;
    ins_vl[ins_cnt]     = vl;
    ins_stride[ins_cnt] = stride;
    ins_vd[ins_cnt]     = vd;
    ins_cnt++;
    model_slide(op == SLD_DOWN, vl << int'(vew), stride << int'(vew), vd, id);
  endtask

  //////////////////////////////////////////////////
  // Drivers and checkers
  //////////////////////////////////////////////////

  // A request shown with ready high is taken on the next rising edge
  task automatic drive_requests();
    int i;
    i = 0;
    while (i < ins_cnt) begin
      @(negedge clk_i);
      req_valid_i  = 1'b1;
      req_id_i     = vid_t'(ins_id[i]);
      req_op_i     = ins_op[i];
      req_vew_i    = ins_vew[i];
      req_vl_i     = vlen_t'(ins_vl[i]);
      req_stride_i = vlen_t'(ins_stride[i]);
      req_vd_i     = vreg_t'(ins_vd[i]);
      if (req_ready_o) i++;
      else saw_full = 1'b1;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic drive_operands(input logic gaps);
    logic held;
    held = 1'b0;
    while (rows_q.size() > 0) begin
      @(negedge clk_i);
      // Gaps only between rows, a shown row stays until taken
      if (!held && gaps && rand_bits(1) == 1) begin
        operand_valid_i = 1'b0;
      end else begin
        operand_valid_i = 1'b1;
        operand_i       = row_data(rows_q[0]);
        held            = !operand_ready_o;
        if (operand_ready_o) void'(rows_q.pop_front());
      end
    end
    @(negedge clk_i);
    operand_valid_i = 1'b0;
  endtask

  task automatic check_row();
    logic [RowW-1:0] got;
    got = result_wdata_o & be_mask(exp_be_q[0]);
    assert (result_addr_o == exp_addr_q[0]) else begin
      $display("Mismatch at %0d ns: result_addr_o = %h, expected %h",
               $time, result_addr_o, exp_addr_q[0]);
      err_cnt++;
    end
    assert (result_be_o == exp_be_q[0]) else begin
      $display("Mismatch at %0d ns: result_be_o = %h, expected %h",
               $time, result_be_o, exp_be_q[0]);
      err_cnt++;
    end
    assert (got == exp_data_q[0]) else begin
      $display("Mismatch at %0d ns: result_wdata_o = %h, expected %h",
               $time, got, exp_data_q[0]);
      err_cnt++;
    end
    void'(exp_addr_q.pop_front());
    void'(exp_be_q.pop_front());
    void'(exp_data_q.pop_front());
  endtask

  // Grant level for the next edge, held low on random cycles if asked
  task automatic collect_results(input logic gaps);
    while (exp_addr_q.size() > 0) begin
      @(negedge clk_i);
      result_gnt_i = gaps ? rand_bits(1) == 1 : 1'b1;
      if (result_req_o && result_gnt_i) check_row();
    end
    @(negedge clk_i);
    result_gnt_i = 1'b0;
  endtask

  task automatic watch_done();
    while (exp_done_q.size() > 0) begin
      @(negedge clk_i);
      if (done_o) begin
        assert (done_id_o == vid_t'(exp_done_q[0])) else begin
          $display("Mismatch at %0d ns: done_id_o = %0d, expected %0d",
                   $time, done_id_o, exp_done_q[0]);
          err_cnt++;
        end
        void'(exp_done_q.pop_front());
      end
    end
  endtask

  task automatic run_slides(input logic gnt_gaps, input logic valid_gaps);
    fork
      drive_requests();
      drive_operands(valid_gaps);
      collect_results(gnt_gaps);
      watch_done();
    join
    @(negedge clk_i);
    assert (!result_req_o && !done_o) else begin
      $display("DUT still shows a row or a done pulse after its last slide ended");
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) failed_cnt++;
    $display("%s: %0d errors", name, err_cnt - errs_before);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Offset of two whole rows, no byte shift
  task automatic aligned_slide_up();
    int errs;
    errs = err_cnt;
    fill_source();
    clear_slides();
    add_slide(1, SLD_UP, EW64, 16, 8, 2);
    run_slides(1'b0, 1'b0);
    report_test("aligned slide up", errs);
  endtask

  // Odd byte offset, last row ends at byte 75
  task automatic odd_slide_down();
    int errs;
    errs = err_cnt;
    fill_source();
    clear_slides();
    add_slide(2, SLD_DOWN, EW8, 75, 13, 4);
    run_slides(1'b0, 1'b0);
    report_test("odd slide down", errs);
  endtask

  task automatic stalled_grant_up();
    int errs;
    errs = err_cnt;
    fill_source();
    clear_slides();
    add_slide(3, SLD_UP, EW16, 100, 21, 1);
    run_slides(1'b1, 1'b0);
    report_test("stalled grant slide up", errs);
  endtask

  task automatic operand_gaps_down();
    int errs;
    errs = err_cnt;
    fill_source();
    clear_slides();
    add_slide(4, SLD_DOWN, EW32, 40, 5, 3);
    run_slides(1'b0, 1'b1);
    report_test("operand gaps slide down", errs);
  endtask

  // Three slides against a queue of two
  task automatic queue_full_burst();
    int errs;
    errs = err_cnt;
    fill_source();
    clear_slides();
    add_slide(5, SLD_UP, EW8, 64, 7, 5);
    add_slide(6, SLD_DOWN, EW16, 48, 3, 6);
    add_slide(7, SLD_UP, EW32, 20, 2, 7);
    run_slides(1'b0, 1'b0);
    assert (saw_full) else begin
      $display("req_ready_o never dropped while the instruction queue was full");
      err_cnt++;
    end
    report_test("queue full burst", errs);
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_id_i        = '0;
    req_op_i        = SLD_UP;
    req_vew_i       = EW8;
    req_vl_i        = '0;
    req_stride_i    = '0;
    req_vd_i        = '0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = 1'b0;
    lfsr_q          = 32'h6c0d_8d3e;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    aligned_slide_up();
    odd_slide_down();
    stalled_grant_up();
    operand_gaps_down();
    queue_full_burst();

    $display("Tests: %0d, failed: %0d, errors: %0d", test_cnt, failed_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sld_unit.f
+incdir+bench
rtl/sld_pkg.sv
rtl/sld_spill_reg.sv
rtl/sld_insn_queue.sv
rtl/sld_issue.sv
rtl/sld_unit.sv
bench/tb_sld_unit.sv
